// ==== hdl/rnd_pkg.sv ====
// binary32 only; exponent is signed biased and must be at least 1 after alignment
package rnd_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // input fraction: carry 27, hidden 26, fraction 25..3, round 2, sticky 1..0
  localparam int FRACT_IN_W = 28;
  // aligned significand: overflow 24, hidden 23, fraction 22..0
  localparam int SIG_W      = 25;
  // stored mantissa
  localparam int MAN_W      = 23;
  // signed biased exponent through the pipe
  localparam int EXP_W      = 10;
  // denormalization shift amount
  localparam int SHR_W      = 5;

  // largest biased exponent of a finite result
  localparam int EXP_MAX_NORM = 254;

  //////////////////////////////////////////////////
  // exception flags
  //////////////////////////////////////////////////

  localparam int FLAG_W   = 6;
  localparam int FLAG_INV = 5;
  localparam int FLAG_INF = 4;
  localparam int FLAG_OVF = 3;
  localparam int FLAG_UNF = 2;
  localparam int FLAG_INE = 1;
  localparam int FLAG_ZER = 0;

  typedef logic [FLAG_W-1:0] flags_t;

  // rounding modes, same codes as the FPU control register
  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,
    RM_TO_ZERO = 2'd1,
    RM_TO_INFP = 2'd2,
    RM_TO_INFM = 2'd3
  } rmode_e;

  //////////////////////////////////////////////////
  // special magnitudes, sign prepended by the user
  //////////////////////////////////////////////////

  // exponent all ones, top fraction bit set
  localparam logic [30:0] QNAN_S = 31'h7fc00000;
  // exponent all ones, fraction zero
  localparam logic [30:0] INF_S  = 31'h7f800000;

endpackage

// ==== hdl/rnd_align.sv ====
// input side; one item at a time, in_ack_o only rises while stage 1 is empty, shift up to 31
`timescale 1ns/1ps

module rnd_align import rnd_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  // four-phase input handshake
  input  logic                         in_req_i,
  output logic                         in_ack_o,
  // unrounded operand
  input  logic                         sign_i,
  input  logic                         sub_zero_i,
  input  rmode_e                       rmode_i,
  input  logic signed [EXP_W-1:0]      exp_i,
  input  logic [FRACT_IN_W-1:0]        fract_i,
  input  logic [SHR_W-1:0]             shr_i,
  input  logic                         inv_i,
  input  logic                         inf_i,
  input  logic                         snan_i,
  input  logic                         qnan_i,
  input  logic                         nan_sign_i,
  // stage 1 to stage 2
  input  logic                         round_taking_i,
  output logic                         align_valid_o,
  output logic                         al_sign_o,
  output rmode_e                       al_rmode_o,
  output logic signed [EXP_W-1:0]      al_exp_o,
  output logic [SIG_W-1:0]             al_sig_o,
  output logic [1:0]                   al_rs_o,
  output logic [4:0]                   al_class_o
);

  //////////////////////////////////////////////////
  // alignment
  //////////////////////////////////////////////////

  logic [SHR_W-1:0]         shr_eff;
  logic [FRACT_IN_W-1:0]    fract_sh;
  logic [FRACT_IN_W-1:0]    sticky_mask;
  logic                     sticky;
  logic signed [EXP_W-1:0]  exp_eff;
  logic                     sign_eff;
  logic                     take;

  // carry pre-shift only when no denormalization shift is asked for
  assign shr_eff = (shr_i != '0) ? shr_i : {{(SHR_W-1){1'b0}}, fract_i[FRACT_IN_W-1]};

  assign fract_sh = fract_i >> shr_eff;

  // ones at positions 0 .. shift+1
  // wraps to all ones once shift+2 passes the top bit
  assign sticky_mask = (FRACT_IN_W'(4) << shr_eff) - FRACT_IN_W'(1);
  assign sticky      = |(fract_i & sticky_mask);

  // exponent follows the shift
  assign exp_eff = exp_i + $signed(EXP_W'(shr_eff));

  // exact zero from a subtraction is -0 only when rounding down
  assign sign_eff = sub_zero_i ? (rmode_i == RM_TO_INFM) : sign_i;

  //////////////////////////////////////////////////
  // handshake and stage 1 register
  //////////////////////////////////////////////////

  // new request, not yet acked, stage 1 empty
  assign take = in_req_i & ~in_ack_o & ~align_valid_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ack_o <= 1'b0;
    end else if (take) begin
      in_ack_o <= 1'b1;
    end else if (!in_req_i) begin
      // return to zero after source drops req
      in_ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      align_valid_o <= 1'b0;
    end else if (take) begin
      align_valid_o <= 1'b1;
    end else if (round_taking_i) begin
      align_valid_o <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (take) begin
      al_sign_o  <= sign_eff;
      al_rmode_o <= rmode_i;
      al_exp_o   <= exp_eff;
      // drop round and sticky source bits
      al_sig_o   <= fract_sh[FRACT_IN_W-1:3];
      al_rs_o    <= {fract_sh[2], sticky};
      al_class_o <= {inv_i, inf_i, snan_i, qnan_i, nan_sign_i};
    end
  end

  // ack only answers a request seen on the previous edge
  a_ack_after_req : assert property (
    @(posedge clk) disable iff (rst)
    $rose(in_ack_o) |-> $past(in_req_i)
  );

endmodule

// ==== hdl/rnd_round.sv ====
// processing part; expects a pre-shifted significand with overflow bit 24 clear
`timescale 1ns/1ps

module rnd_round import rnd_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // from stage 1
  input  logic                     align_valid_i,
  output logic                     round_taking_o,
  input  logic                     al_sign_i,
  input  rmode_e                   al_rmode_i,
  input  logic signed [EXP_W-1:0]  al_exp_i,
  input  logic [SIG_W-1:0]         al_sig_i,
  input  logic [1:0]               al_rs_i,
  input  logic [4:0]               al_class_i,
  // to output stage
  input  logic                     pack_taking_i,
  output logic                     round_valid_o,
  output logic                     rd_sign_o,
  output logic signed [EXP_W-1:0]  rd_exp_o,
  output logic [MAN_W:0]           rd_sig_o,
  output logic                     rd_lost_o,
  output logic [4:0]               rd_class_o
);

  //////////////////////////////////////////////////
  // rounding decision
  //////////////////////////////////////////////////

  logic                     lsb;
  logic                     rbit;
  logic                     sbit;
  logic                     lost;
  logic                     rnd_up;
  logic [SIG_W-1:0]         sig_rnd;
  logic                     sig_ovf;
  logic [MAN_W:0]           sig_norm;
  logic signed [EXP_W-1:0]  exp_norm;

  assign lsb  = al_sig_i[0];
  assign rbit = al_rs_i[1];
  assign sbit = al_rs_i[0];
  assign lost = rbit | sbit;

  always_comb begin
    case (al_rmode_i)
      // ties go to even
      RM_NEAREST: rnd_up = rbit & (sbit | lsb);
      RM_TO_INFP: rnd_up = ~al_sign_i & lost;
      RM_TO_INFM: rnd_up = al_sign_i & lost;
      default:    rnd_up = 1'b0;
    endcase
  end

  // increment, then renormalize on carry into bit 24
  assign sig_rnd  = al_sig_i + SIG_W'(rnd_up);
  assign sig_ovf  = sig_rnd[SIG_W-1];
  assign sig_norm = sig_ovf ? sig_rnd[SIG_W-1:1] : sig_rnd[SIG_W-2:0];
  assign exp_norm = al_exp_i + $signed(EXP_W'(sig_ovf));

  //////////////////////////////////////////////////
  // stage 2 register
  //////////////////////////////////////////////////

  // empty, or handing over on this edge
  assign round_taking_o = align_valid_i & (~round_valid_o | pack_taking_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      round_valid_o <= 1'b0;
    end else if (round_taking_o) begin
      round_valid_o <= 1'b1;
    end else if (pack_taking_i) begin
      round_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (round_taking_o) begin
      rd_sign_o  <= al_sign_i;
      rd_exp_o   <= exp_norm;
      rd_sig_o   <= sig_norm;
      rd_lost_o  <= lost;
      rd_class_o <= al_class_i;
    end
  end

  // back-pressure from the output register holds the item
  a_hold_stage2 : assert property (
    @(posedge clk) disable iff (rst)
    round_valid_o && !pack_taking_i |=>
      round_valid_o && $stable(rd_sig_o) && $stable(rd_exp_o)
  );

endmodule

// ==== hdl/rnd_pack.sv ====
// output side; holds one result until the sink completes the four-phase return to zero
`timescale 1ns/1ps

module rnd_pack import rnd_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // from stage 2
  input  logic                     round_valid_i,
  output logic                     pack_taking_o,
  input  logic                     rd_sign_i,
  input  logic signed [EXP_W-1:0]  rd_exp_i,
  input  logic [MAN_W:0]           rd_sig_i,
  input  logic                     rd_lost_i,
  input  logic [4:0]               rd_class_i,
  // four-phase output handshake
  output logic                     out_req_o,
  input  logic                     out_ack_i,
  output logic [31:0]              result_o,
  output flags_t                   flags_o
);

  //////////////////////////////////////////////////
  // class and path selection
  //////////////////////////////////////////////////

  logic             c_inv;
  logic             c_inf;
  logic             c_snan;
  logic             c_qnan;
  logic             c_nan_sign;
  logic             nan_path;
  logic             inv_path;
  logic             inf_path;
  logic             dn_path;
  logic [MAN_W-1:0] man;
  logic [31:0]      result_nx;
  flags_t           flags_nx;
  logic             ovf;

  assign {c_inv, c_inf, c_snan, c_qnan, c_nan_sign} = rd_class_i;

  assign man = rd_sig_i[MAN_W-1:0];

  // priority: nan operand, invalid op, overflow/inf, denormal, normal
  assign nan_path = c_snan | c_qnan;
  assign inv_path = ~nan_path & c_inv;
  assign inf_path = ~nan_path & ~c_inv &
                    ((int'(rd_exp_i) > EXP_MAX_NORM) | c_inf);
  // hidden bit lost, either tiny or zero
  assign dn_path  = ~nan_path & ~c_inv & ~inf_path & ~rd_sig_i[MAN_W];

  always_comb begin
    if (nan_path) begin
      result_nx = {c_nan_sign, QNAN_S};
    end else if (c_inv) begin
      result_nx = {rd_sign_i, QNAN_S};
    end else if (inf_path) begin
      result_nx = {rd_sign_i, INF_S};
    end else if (dn_path) begin
      result_nx = {rd_sign_i, 8'd0, man};
    end else begin
      result_nx = {rd_sign_i, rd_exp_i[7:0], man};
    end
  end

  //////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////

  // overflow only for a finite operand pushed past 254
  assign ovf = inf_path & ~c_inf;

  always_comb begin
    flags_nx           = '0;
    flags_nx[FLAG_INV] = c_inv | c_snan;
    flags_nx[FLAG_INF] = inf_path;
    flags_nx[FLAG_OVF] = ovf;
    // nothing inexact about a NaN result
    flags_nx[FLAG_INE] = ~nan_path & ~inv_path & (rd_lost_i | ovf);
    flags_nx[FLAG_UNF] = dn_path & rd_lost_i;
    flags_nx[FLAG_ZER] = dn_path & (man == '0);
  end

  //////////////////////////////////////////////////
  // output holding register
  //////////////////////////////////////////////////

  // free once req is low and sink has dropped ack
  assign pack_taking_o = round_valid_i & ~out_req_o & ~out_ack_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_req_o <= 1'b0;
      flags_o   <= '0;
    end else if (pack_taking_o) begin
      out_req_o <= 1'b1;
      flags_o   <= flags_nx;
    end else if (out_req_o && out_ack_i) begin
      out_req_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pack_taking_o) begin
      result_o <= result_nx;
    end
  end

  // sink may sample any time while req is up
  a_out_stable : assert property (
    @(posedge clk) disable iff (rst)
    out_req_o |=> $stable(result_o) && $stable(flags_o)
  );

endmodule

// ==== hdl/rnd_top.sv ====
// binary32 rounding pipe; up to three items in flight, four-phase on both ends
`timescale 1ns/1ps

module rnd_top import rnd_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // input side
  input  logic                     in_req_i,
  output logic                     in_ack_o,
  input  logic                     sign_i,
  input  logic                     sub_zero_i,
  input  rmode_e                   rmode_i,
  input  logic signed [EXP_W-1:0]  exp_i,
  input  logic [FRACT_IN_W-1:0]    fract_i,
  input  logic [SHR_W-1:0]         shr_i,
  input  logic                     inv_i,
  input  logic                     inf_i,
  input  logic                     snan_i,
  input  logic                     qnan_i,
  input  logic                     nan_sign_i,
  // output side
  output logic                     out_req_o,
  input  logic                     out_ack_i,
  output logic [31:0]              result_o,
  output flags_t                   flags_o
);

  //////////////////////////////////////////////////
  // stage 1 to stage 2
  //////////////////////////////////////////////////

  logic                     align_valid;
  logic                     round_taking;
  logic                     al_sign;
  rmode_e                   al_rmode;
  logic signed [EXP_W-1:0]  al_exp;
  logic [SIG_W-1:0]         al_sig;
  logic [1:0]               al_rs;
  logic [4:0]               al_class;

  // stage 2 to output
  logic                     round_valid;
  logic                     pack_taking;
  logic                     rd_sign;
  logic signed [EXP_W-1:0]  rd_exp;
  logic [MAN_W:0]           rd_sig;
  logic                     rd_lost;
  logic [4:0]               rd_class;

  rnd_align u_rnd_align (
    .clk            (clk),
    .rst            (rst),
    .in_req_i       (in_req_i),
    .in_ack_o       (in_ack_o),
    .sign_i         (sign_i),
    .sub_zero_i     (sub_zero_i),
    .rmode_i        (rmode_i),
    .exp_i          (exp_i),
    .fract_i        (fract_i),
    .shr_i          (shr_i),
    .inv_i          (inv_i),
    .inf_i          (inf_i),
    .snan_i         (snan_i),
    .qnan_i         (qnan_i),
    .nan_sign_i     (nan_sign_i),
    .round_taking_i (round_taking),
    .align_valid_o  (align_valid),
    .al_sign_o      (al_sign),
    .al_rmode_o     (al_rmode),
    .al_exp_o       (al_exp),
    .al_sig_o       (al_sig),
    .al_rs_o        (al_rs),
    .al_class_o     (al_class)
  );

  rnd_round u_rnd_round (
    .clk            (clk),
    .rst            (rst),
    .align_valid_i  (align_valid),
    .round_taking_o (round_taking),
    .al_sign_i      (al_sign),
    .al_rmode_i     (al_rmode),
    .al_exp_i       (al_exp),
    .al_sig_i       (al_sig),
    .al_rs_i        (al_rs),
    .al_class_i     (al_class),
    .pack_taking_i  (pack_taking),
    .round_valid_o  (round_valid),
    .rd_sign_o      (rd_sign),
    .rd_exp_o       (rd_exp),
    .rd_sig_o       (rd_sig),
    .rd_lost_o      (rd_lost),
    .rd_class_o     (rd_class)
  );

  rnd_pack u_rnd_pack (
    .clk            (clk),
    .rst            (rst),
    .round_valid_i  (round_valid),
    .pack_taking_o  (pack_taking),
    .rd_sign_i      (rd_sign),
    .rd_exp_i       (rd_exp),
    .rd_sig_i       (rd_sig),
    .rd_lost_i      (rd_lost),
    .rd_class_i     (rd_class),
    .out_req_o      (out_req_o),
    .out_ack_i      (out_ack_i),
    .result_o       (result_o),
    .flags_o        (flags_o)
  );

endmodule

// ==== verification/rnd_model.svh ====
// reference model and operand generator; needs rnd_pkg imported by the including module
`ifndef RND_MODEL_SVH
`define RND_MODEL_SVH

// one unrounded operand as the source hands it over
typedef struct packed {
  logic                     sign;
  logic                     sub_zero;
  rmode_e                   rmode;
  logic signed [EXP_W-1:0]  exp;
  logic [FRACT_IN_W-1:0]    fract;
  logic [SHR_W-1:0]         shr;
  logic                     inv;
  logic                     inf;
  logic                     snan;
  logic                     qnan;
  logic                     nan_sign;
} operand_t;

//////////////////////////////////////////////////
// expected {flags, result} for one operand
//////////////////////////////////////////////////

function automatic logic [FLAG_W+31:0] round_model(input operand_t op);
  int                     shift;
  int                     e;
  int                     i;
  logic [FRACT_IN_W-1:0]  fr;
  logic [SIG_W-1:0]       sig;
  logic                   r_bit;
  logic                   st_bit;
  logic                   lost;
  logic                   up;
  logic                   s;
  logic [31:0]            res;
  flags_t                 fl;
  // carry bit alone asks for a one-place shift
  shift = (op.shr != '0) ? int'(op.shr) : int'(op.fract[FRACT_IN_W-1]);
  fr    = op.fract >> shift;
  sig   = fr[FRACT_IN_W-1:3];
  r_bit = fr[2];
  // sticky covers every source bit up to shift+1
  st_bit = 1'b0;
  for (i = 0; i < FRACT_IN_W; i++) begin
    if (i <= shift + 1) begin
      st_bit = st_bit | op.fract[i];
    end
  end
  e    = int'($signed(op.exp)) + shift;
  s    = op.sub_zero ? (op.rmode == RM_TO_INFM) : op.sign;
  lost = r_bit | st_bit;
  case (op.rmode)
    RM_NEAREST: up = r_bit & (st_bit | sig[0]);
    RM_TO_INFP: up = ~s & lost;
    RM_TO_INFM: up = s & lost;
    default:    up = 1'b0;
  endcase
  sig = sig + SIG_W'(up);
  // carry out of the significand, renormalize
  if (sig[SIG_W-1]) begin
    sig = sig >> 1;
    e   = e + 1;
  end
  fl = '0;
  if (op.snan || op.qnan) begin
    res           = {op.nan_sign, QNAN_S};
    fl[FLAG_INV]  = op.inv | op.snan;
  end else if (op.inv) begin
    res           = {s, QNAN_S};
    fl[FLAG_INV]  = 1'b1;
  end else if (e > EXP_MAX_NORM || op.inf) begin
    res           = {s, INF_S};
    fl[FLAG_INF]  = 1'b1;
    fl[FLAG_OVF]  = ~op.inf;
    fl[FLAG_INE]  = lost | ~op.inf;
  end else if (!sig[MAN_W]) begin
    // tiny or zero
    res           = {s, 8'd0, sig[MAN_W-1:0]};
    fl[FLAG_UNF]  = lost;
    fl[FLAG_ZER]  = (sig[MAN_W-1:0] == '0);
    fl[FLAG_INE]  = lost;
  end else begin
    res           = {s, 8'(e), sig[MAN_W-1:0]};
    fl[FLAG_INE]  = lost;
  end
  return {fl, res};
endfunction

//////////////////////////////////////////////////
// random operand, exponent after alignment >= 1
//////////////////////////////////////////////////

function automatic operand_t random_operand();
  operand_t op;
  int       pick;
  op          = '0;
  pick        = int'($urandom_range(15, 0));
  op.sign     = 1'($urandom_range(1, 0));
  op.rmode    = rmode_e'(2'($urandom_range(3, 0)));
  op.fract    = FRACT_IN_W'($urandom);
  op.nan_sign = 1'($urandom_range(1, 0));
  // normalized: hidden bit or carry bit set
  op.fract[FRACT_IN_W-1] = 1'($urandom_range(1, 0));
  if (!op.fract[FRACT_IN_W-1]) begin
    op.fract[FRACT_IN_W-2] = 1'b1;
  end
  op.exp = EXP_W'($urandom_range(254, 1));
  if (pick == 7) begin
    // near and past the top
    op.exp = EXP_W'($urandom_range(300, 250));
  end else if (pick >= 8 && pick <= 10) begin
    op.fract = FRACT_IN_W'($urandom);
    op.shr   = SHR_W'($urandom_range(31, 1));
    op.exp   = EXP_W'(1 - int'(op.shr));
  end else if (pick == 11) begin
    // all-ones mantissa after a 1-place shift, may round into hidden
    op.fract = {1'b0, 24'hffffff, 3'($urandom)};
    op.shr   = SHR_W'(1);
    op.exp   = '0;
  end else if (pick == 12) begin
    op.fract    = '0;
    op.sub_zero = 1'($urandom_range(1, 0));
  end else if (pick == 13) begin
    op.inf = 1'b1;
  end else if (pick == 14) begin
    op.snan = 1'($urandom_range(1, 0));
    op.qnan = ~op.snan;
    op.inv  = 1'($urandom_range(1, 0));
  end else if (pick == 15) begin
    op.inv = 1'b1;
  end
  return op;
endfunction

`endif

// ==== verification/rnd_tb.sv ====
// random operands from a fixed seed against a local model; sink delays 0..ACK_DELAY_MAX
`timescale 1ns/1ps

module rnd_tb import rnd_pkg::*; ();

  localparam int          N_TESTS       = 4000;
  localparam int          ACK_DELAY_MAX = 4;
  localparam int unsigned SEED          = 32'h4dc62331;
  // per item the sink delay plus handshake overhead, reset margin included
  localparam int unsigned WATCHDOG_NS   = (N_TESTS + 4) * (ACK_DELAY_MAX + 8) * 100;

  logic                     clk;
  logic                     rst;
  logic                     in_req_i;
  logic                     in_ack_o;
  logic                     sign_i;
  logic                     sub_zero_i;
  rmode_e                   rmode_i;
  logic signed [EXP_W-1:0]  exp_i;
  logic [FRACT_IN_W-1:0]    fract_i;
  logic [SHR_W-1:0]         shr_i;
  logic                     inv_i;
  logic                     inf_i;
  logic                     snan_i;
  logic                     qnan_i;
  logic                     nan_sign_i;
  logic                     out_req_o;
  logic                     out_ack_i;
  logic [31:0]              result_o;
  flags_t                   flags_o;

  `include "rnd_model.svh"

  // expected {flags, result}, oldest first
  logic [FLAG_W+31:0] exp_q[$];
  int                 n_sent;
  int                 n_received;

  rnd_top u_rnd_top (
    .clk        (clk),
    .rst        (rst),
    .in_req_i   (in_req_i),
    .in_ack_o   (in_ack_o),
    .sign_i     (sign_i),
    .sub_zero_i (sub_zero_i),
    .rmode_i    (rmode_i),
    .exp_i      (exp_i),
    .fract_i    (fract_i),
    .shr_i      (shr_i),
    .inv_i      (inv_i),
    .inf_i      (inf_i),
    .snan_i     (snan_i),
    .qnan_i     (qnan_i),
    .nan_sign_i (nan_sign_i),
    .out_req_o  (out_req_o),
    .out_ack_i  (out_ack_i),
    .result_o   (result_o),
    .flags_o    (flags_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "run aborted");
  endtask

  //////////////////////////////////////////////////
  // source, sink, protocol watch
  //////////////////////////////////////////////////

  task automatic run_source();
    operand_t op;
    int       n;
    for (n = 0; n < N_TESTS; n++) begin
      op = random_operand();
      @(posedge clk);
      sign_i     <= op.sign;
      sub_zero_i <= op.sub_zero;
      rmode_i    <= op.rmode;
      exp_i      <= op.exp;
      fract_i    <= op.fract;
      shr_i      <= op.shr;
      inv_i      <= op.inv;
      inf_i      <= op.inf;
      snan_i     <= op.snan;
      qnan_i     <= op.qnan;
      nan_sign_i <= op.nan_sign;
      in_req_i   <= 1'b1;
      @(negedge clk);
      while (!in_ack_o) @(negedge clk);
      // captured on the edge that raised ack
      exp_q.push_back(round_model(op));
      n_sent++;
      @(posedge clk);
      in_req_i <= 1'b0;
      // junk on the data lines once req is gone
      fract_i  <= FRACT_IN_W'($urandom);
      @(negedge clk);
      while (in_ack_o) @(negedge clk);
    end
  endtask

  task automatic run_sink();
    logic [FLAG_W+31:0] expected;
    int                 d;
    forever begin
      @(negedge clk);
      while (!out_req_o) @(negedge clk);
      if (exp_q.size() == 0) begin
        fail_run("result arrived with no item outstanding");
      end
      expected = exp_q.pop_front();
      check_value("result_o", expected[31:0], result_o);
      check_value("flags_o", 32'(expected[FLAG_W+31:32]), 32'(flags_o));
      n_received++;
      d = int'($urandom_range(ACK_DELAY_MAX, 0));
      repeat (d) @(posedge clk);
      @(posedge clk);
      out_ack_i <= 1'b1;
      @(negedge clk);
      while (out_req_o) @(negedge clk);
      @(posedge clk);
      out_ack_i <= 1'b0;
    end
  endtask

  // four-phase order on both ends
  task automatic watch_handshakes();
    logic prev_in_ack;
    logic prev_out_req;
    prev_in_ack  = 1'b0;
    prev_out_req = 1'b0;
    forever begin
      @(negedge clk);
      if (!prev_in_ack && in_ack_o && !in_req_i) begin
        fail_run("in_ack_o rose while in_req_i was low");
      end
      if (prev_in_ack && !in_ack_o && in_req_i) begin
        fail_run("in_ack_o dropped while in_req_i was still high");
      end
      if (prev_out_req && !out_req_o && !out_ack_i) begin
        fail_run("out_req_o dropped before out_ack_i was raised");
      end
      if (!prev_out_req && out_req_o && out_ack_i) begin
        fail_run("out_req_o rose while out_ack_i was still high");
      end
      prev_in_ack  = in_ack_o;
      prev_out_req = out_req_o;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run("timeout, not every result came out of the pipeline");
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    n_sent     = 0;
    n_received = 0;
    rst        = 1'b1;
    in_req_i   = 1'b0;
    sign_i     = 1'b0;
    sub_zero_i = 1'b0;
    rmode_i    = RM_NEAREST;
    exp_i      = '0;
    fract_i    = '0;
    shr_i      = '0;
    inv_i      = 1'b0;
    inf_i      = 1'b0;
    snan_i     = 1'b0;
    qnan_i     = 1'b0;
    nan_sign_i = 1'b0;
    out_ack_i  = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // idle state straight out of reset
    @(negedge clk);
    check_value("in_ack_o", 32'd0, 32'(in_ack_o));
    check_value("out_req_o", 32'd0, 32'(out_req_o));
    check_value("flags_o", 32'd0, 32'(flags_o));
    fork
      run_source();
      run_sink();
      watch_handshakes();
    join_none
    wait (n_received == N_TESTS);
    // room for a stray duplicate to show up
    repeat (10) @(posedge clk);
    if (exp_q.size() == 0 && n_sent == N_TESTS) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("scoreboard still holds results at the end of the run");
      $display("Checks failed");
      $fatal(1, "leftover expected results");
    end
  end

endmodule

// ==== all.f ====
+incdir+verification
hdl/rnd_pkg.sv
hdl/rnd_align.sv
hdl/rnd_round.sv
hdl/rnd_pack.sv
hdl/rnd_top.sv
verification/rnd_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rounding pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module rnd_tb -Mdir obj_dir

out="$(./obj_dir/Vrnd_tb 2>&1 || true)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
